//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_zxuno_regs
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only if the exact pass line shows up in the output
sim: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/coreid_rom.sv
module coreid_rom #(
   parameter logic [63:0] CORE_ID_TEXT = zxuno_pkg::CORE_ID_TEXT
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  zxuno_pkg::reg_access_t  access,
   output zxuno_pkg::rd_src_t      src
);

   localparam int NUM_CHARS = $bits(CORE_ID_TEXT) / 8;
   localparam int PTR_W     = $clog2(NUM_CHARS + 1);

   logic             id_read;
   logic [PTR_W-1:0] ptr_q;
   logic [7:0]       char_data;

   assign id_read = access.rd && (access.regnum == zxuno_pkg::REG_COREID);

   // Character under the pointer or zero past the end
   always_comb begin
      char_data = '0;
      for (int i = 0; i < NUM_CHARS; i++) begin
         if (ptr_q == PTR_W'(i)) begin
            char_data = CORE_ID_TEXT[8*(NUM_CHARS-1-i) +: 8];
         end
      end
   end

   // Walk the string and rewind on a new register selection
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr_q <= '0;
      end else if (access.regaddr_changed) begin
         ptr_q <= '0;
      end else if (id_read && (ptr_q != PTR_W'(NUM_CHARS))) begin
         ptr_q <= ptr_q + 1'b1;
      end
   end

   always_comb begin
      src.oe   = id_read;
      src.data = char_data;
   end

endmodule

//--- rtl/cpu_read_arbiter.sv
module cpu_read_arbiter (
   input  logic                clk,
   input  logic                arst_n,
   input  zxuno_pkg::rd_src_t  addr_src,
   input  zxuno_pkg::rd_src_t  coreid_src,
   input  zxuno_pkg::rd_src_t  devopt_src,
   input  zxuno_pkg::rd_src_t  line_src,
   input  zxuno_pkg::rd_src_t  ctrl_src,
   output logic [7:0]          rdata,
   output logic                rdata_valid
);

   zxuno_pkg::rd_src_t grant;

   // First enabled source wins in fixed priority order
   always_comb begin
      if (addr_src.oe)        grant = addr_src;
      else if (coreid_src.oe) grant = coreid_src;
      else if (devopt_src.oe) grant = devopt_src;
      else if (line_src.oe)   grant = line_src;
      else if (ctrl_src.oe)   grant = ctrl_src;
      else                    grant = '{oe: 1'b0, data: 8'hFF};
   end

   // ----------------------------------------
   // Output stage to the CPU
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata       <= 8'hFF;
         rdata_valid <= 1'b0;
      end else begin
         rdata       <= grant.data;
         rdata_valid <= grant.oe;
      end
   end

endmodule

//--- rtl/device_options.sv
module device_options (
   input  logic                      clk,
   input  logic                      arst_n,
   input  zxuno_pkg::reg_access_t    access,
   input  logic [7:0]                wdata,
   output zxuno_pkg::rd_src_t        src,
   output zxuno_pkg::devopt_flags_t  devopt
);

   logic                    reg_hit;
   zxuno_pkg::devopt_word_u opt_q;

   assign reg_hit = (access.regnum == zxuno_pkg::REG_DEVOPTIONS);

   // ----------------------------------------
   // Options register
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         opt_q.raw <= '0;
      end else if (access.wr && reg_hit) begin
         opt_q.raw <= wdata;
      end
   end

   // Readback as a plain byte
   always_comb begin
      src.oe   = access.rd && reg_hit;
      src.data = opt_q.raw;
   end

   // Individual enables towards the rest of the machine
   assign devopt = opt_q.flags;

endmodule

//--- rtl/rasterint_ctrl.sv
module rasterint_ctrl (
   input  logic                    clk,
   input  logic                    arst_n,
   input  zxuno_pkg::reg_access_t  access,
   input  logic [7:0]              wdata,
   output zxuno_pkg::rd_src_t      src_line,
   output zxuno_pkg::rd_src_t      src_ctrl,
   output zxuno_pkg::raster_cfg_t  raster_cfg
);

   logic                   line_hit;
   logic                   ctrl_hit;
   zxuno_pkg::raster_cfg_t cfg_q;

   assign line_hit = (access.regnum == zxuno_pkg::REG_RASTERLINE);
   assign ctrl_hit = (access.regnum == zxuno_pkg::REG_RASTERCTRL);

   // ----------------------------------------
   // Line and control registers
   // ----------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg_q <= '0;
      end else if (access.wr) begin
         if (line_hit) begin
            cfg_q.raster_line[7:0] <= wdata;
         end
         // Enable in bit 2, retrace disable in bit 1 and line MSB in bit 0
         if (ctrl_hit) begin
            cfg_q.rasterint_enable    <= wdata[2];
            cfg_q.vretraceint_disable <= wdata[1];
            cfg_q.raster_line[8]      <= wdata[0];
         end
      end
   end

   // Readback with unused bits as zero
   always_comb begin
      src_line.oe   = access.rd && line_hit;
      src_line.data = cfg_q.raster_line[7:0];
      src_ctrl.oe   = access.rd && ctrl_hit;
      src_ctrl.data = {5'b00000,
                       cfg_q.rasterint_enable,
                       cfg_q.vretraceint_disable,
                       cfg_q.raster_line[8]};
   end

   assign raster_cfg = cfg_q;

endmodule

//--- rtl/zxuno_pkg.sv
package zxuno_pkg;

   // ----------------------------------------
   // I/O ports and register numbers
   // ----------------------------------------
   localparam logic [15:0] ZXUNO_ADDR_PORT = 16'hFC3B;
   localparam logic [15:0] ZXUNO_DATA_PORT = 16'hFD3B;

   localparam logic [7:0] REG_RASTERLINE = 8'h0C;
   localparam logic [7:0] REG_RASTERCTRL = 8'h0D;
   localparam logic [7:0] REG_DEVOPTIONS = 8'h0E;
   localparam logic [7:0] REG_COREID     = 8'hFF;

   // Default core string with the first character in the top byte
   localparam logic [63:0] CORE_ID_TEXT = "ZXUNOREG";

   // ----------------------------------------
   // Bus and register types
   // ----------------------------------------
   typedef struct packed {
      logic [15:0] addr;
      logic        iorq;
      logic        rd;
      logic        wr;
      logic [7:0]  wdata;
   } cpu_io_t;

   typedef struct packed {
      logic [7:0] regnum;
      logic       rd;
      logic       wr;
      logic       regaddr_changed;
   } reg_access_t;

   // One contender for the CPU read bus
   typedef struct packed {
      logic       oe;
      logic [7:0] data;
   } rd_src_t;

   typedef struct packed {
      logic disable_radas;
      logic disable_ulaplus;
      logic disable_timexscr;
      logic disable_spisd;
      logic enable_timexmmu;
      logic disable_romsel1f;
      logic disable_7ffd;
      logic disable_ay;
   } devopt_flags_t;

   // Same byte seen as raw register or as option flags
   typedef union packed {
      logic [7:0]    raw;
      devopt_flags_t flags;
   } devopt_word_u;

   typedef struct packed {
      logic       rasterint_enable;
      logic       vretraceint_disable;
      logic [8:0] raster_line;
   } raster_cfg_t;

endpackage

//--- rtl/zxuno_reg_port.sv
module zxuno_reg_port (
   input  logic                    clk,
   input  logic                    arst_n,
   input  zxuno_pkg::cpu_io_t      bus,
   output zxuno_pkg::reg_access_t  access,
   output zxuno_pkg::rd_src_t      addr_src
);

   logic       addr_hit;
   logic       data_hit;
   logic [7:0] regnum_q;
   logic       addr_written_q;

   // ----------------------------------------
   // Port decode
   // ----------------------------------------
   assign addr_hit = bus.iorq && (bus.addr == zxuno_pkg::ZXUNO_ADDR_PORT);
   assign data_hit = bus.iorq && (bus.addr == zxuno_pkg::ZXUNO_DATA_PORT);

   // Register number and the change pulse that follows a write to it
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         regnum_q       <= '0;
         addr_written_q <= 1'b0;
      end else begin
         addr_written_q <= addr_hit && bus.wr;
         if (addr_hit && bus.wr) begin
            regnum_q <= bus.wdata;
         end
      end
   end

   // ----------------------------------------
   // Strobes towards the register peers
   // ----------------------------------------
   always_comb begin
      access.regnum          = regnum_q;
      access.rd              = data_hit && bus.rd;
      access.wr              = data_hit && bus.wr;
      access.regaddr_changed = addr_written_q;
   end

   // Address port reads back the selected register number
   always_comb begin
      addr_src.oe   = addr_hit && bus.rd;
      addr_src.data = regnum_q;
   end

endmodule

//--- rtl/zxuno_regs_top.sv
module zxuno_regs_top #(
   parameter logic [63:0] CORE_ID_TEXT = zxuno_pkg::CORE_ID_TEXT
) (
   input  logic                      clk,
   input  logic                      arst_n,
   input  zxuno_pkg::cpu_io_t        bus,
   output logic [7:0]                rdata,
   output logic                      rdata_valid,
   output zxuno_pkg::devopt_flags_t  devopt,
   output zxuno_pkg::raster_cfg_t    raster_cfg
);

   zxuno_pkg::reg_access_t access;

   // Read sources in arbitration order
   zxuno_pkg::rd_src_t addr_src;
   zxuno_pkg::rd_src_t coreid_src;
   zxuno_pkg::rd_src_t devopt_src;
   zxuno_pkg::rd_src_t line_src;
   zxuno_pkg::rd_src_t ctrl_src;

   // ----------------------------------------
   // Port decode
   // ----------------------------------------
   zxuno_reg_port i_reg_port (
      .clk      (clk),
      .arst_n   (arst_n),
      .bus      (bus),
      .access   (access),
      .addr_src (addr_src)
   );

   // ----------------------------------------
   // Register peers
   // ----------------------------------------
   coreid_rom #(
      .CORE_ID_TEXT (CORE_ID_TEXT)
   ) i_coreid (
      .clk    (clk),
      .arst_n (arst_n),
      .access (access),
      .src    (coreid_src)
   );

   device_options i_devopt (
      .clk    (clk),
      .arst_n (arst_n),
      .access (access),
      .wdata  (bus.wdata),
      .src    (devopt_src),
      .devopt (devopt)
   );

   rasterint_ctrl i_rasterint (
      .clk        (clk),
      .arst_n     (arst_n),
      .access     (access),
      .wdata      (bus.wdata),
      .src_line   (line_src),
      .src_ctrl   (ctrl_src),
      .raster_cfg (raster_cfg)
   );

   cpu_read_arbiter i_arbiter (
      .clk         (clk),
      .arst_n      (arst_n),
      .addr_src    (addr_src),
      .coreid_src  (coreid_src),
      .devopt_src  (devopt_src),
      .line_src    (line_src),
      .ctrl_src    (ctrl_src),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

endmodule

//--- tb.f
rtl/zxuno_pkg.sv
rtl/zxuno_reg_port.sv
rtl/coreid_rom.sv
rtl/device_options.sv
rtl/rasterint_ctrl.sv
rtl/cpu_read_arbiter.sv
rtl/zxuno_regs_top.sv
verif/zxuno_regs_assertions.sv
verif/tb_zxuno_regs.sv

//--- verif/tb_zxuno_regs.sv
module tb_zxuno_regs;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int RESP_TIMEOUT = 8;

   localparam logic [15:0] ADDR_PORT = zxuno_pkg::ZXUNO_ADDR_PORT;
   localparam logic [15:0] DATA_PORT = zxuno_pkg::ZXUNO_DATA_PORT;

   logic                     clk;
   logic                     arst_n;
   zxuno_pkg::cpu_io_t       bus;
   logic [7:0]               rdata;
   logic                     rdata_valid;
   zxuno_pkg::devopt_flags_t devopt;
   zxuno_pkg::raster_cfg_t   raster_cfg;
   logic [31:0]              lfsr_q;

   zxuno_regs_top #(
      .CORE_ID_TEXT (zxuno_pkg::CORE_ID_TEXT)
   ) i_dut (
      .clk         (clk),
      .arst_n      (arst_n),
      .bus         (bus),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .devopt      (devopt),
      .raster_cfg  (raster_cfg)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("test failed");
      $fatal(1, "simulation stopped");
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   task automatic take_random_byte(output logic [7:0] value);
      value = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         value  = {value[6:0], lfsr_q[0]};
      end
   endtask

   function automatic void set_bus_idle();
      bus = '0;
   endfunction

   task automatic write_port(input logic [15:0] port, input logic [7:0] value);
      @(negedge clk);
      bus.addr  = port;
      bus.wdata = value;
      bus.iorq  = 1'b1;
      bus.wr    = 1'b1;
      @(negedge clk);
      set_bus_idle();
   endtask

   task automatic read_port(input logic [15:0] port, input logic expect_valid);
      int waited;
      @(negedge clk);
      bus.addr = port;
      bus.iorq = 1'b1;
      bus.rd   = 1'b1;
      @(negedge clk);
      set_bus_idle();
      waited = 0;
      while (expect_valid && !rdata_valid && (waited < RESP_TIMEOUT)) begin
         @(negedge clk);
         waited++;
      end
      if (expect_valid && !rdata_valid) begin
         stop_with_failure("timeout waiting for read data after a bus read");
      end
   endtask

   always @(negedge clk) begin
      if (i_dut.i_checks.any_failed) begin
         stop_with_failure($sformatf("** Error at time %0t: DUT output check failed", $time));
      end
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial begin
      logic [7:0] value;
      arst_n = 1'b0;
      lfsr_q = 32'h8639;
      set_bus_idle();
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      for (int i = 0; i < 4; i++) begin
         take_random_byte(value);
         write_port(ADDR_PORT, value);
         read_port(ADDR_PORT, 1'b1);
      end

      write_port(ADDR_PORT, zxuno_pkg::REG_DEVOPTIONS);
      for (int i = 0; i < 4; i++) begin
         take_random_byte(value);
         write_port(DATA_PORT, value);
         read_port(DATA_PORT, 1'b1);
      end

      // Full random bytes so the unused control bits get exercised
      for (int i = 0; i < 3; i++) begin
         write_port(ADDR_PORT, zxuno_pkg::REG_RASTERLINE);
         take_random_byte(value);
         write_port(DATA_PORT, value);
         read_port(DATA_PORT, 1'b1);
         write_port(ADDR_PORT, zxuno_pkg::REG_RASTERCTRL);
         take_random_byte(value);
         write_port(DATA_PORT, value);
         read_port(DATA_PORT, 1'b1);
      end

      // Whole string plus two reads past its end and then a restart midway
      write_port(ADDR_PORT, zxuno_pkg::REG_COREID);
      repeat (10) read_port(DATA_PORT, 1'b1);
      write_port(ADDR_PORT, zxuno_pkg::REG_COREID);
      repeat (3) read_port(DATA_PORT, 1'b1);
      write_port(ADDR_PORT, zxuno_pkg::REG_COREID);
      repeat (9) read_port(DATA_PORT, 1'b1);

      write_port(ADDR_PORT, 8'h42);
      read_port(DATA_PORT, 1'b0);
      write_port(ADDR_PORT, 8'h00);
      read_port(DATA_PORT, 1'b0);
      read_port(16'h00FE, 1'b0);

      repeat (4) @(negedge clk);
      if (i_dut.i_checks.any_failed) begin
         stop_with_failure("a check on the DUT outputs failed");
      end else begin
         $display("test passed");
         $finish;
      end
   end

endmodule

//--- verif/zxuno_regs_assertions.sv
module zxuno_regs_assertions #(
   parameter logic [63:0] CORE_ID_TEXT = zxuno_pkg::CORE_ID_TEXT
) (
   input logic                      clk,
   input logic                      arst_n,
   input zxuno_pkg::cpu_io_t        bus,
   input logic [7:0]                rdata,
   input logic                      rdata_valid,
   input zxuno_pkg::devopt_flags_t  devopt,
   input zxuno_pkg::raster_cfg_t    raster_cfg
);

   localparam int NUM_CHARS = $bits(CORE_ID_TEXT) / 8;

   // One sticky flag per assertion
   logic fail_reset  = 1'b0;
   logic fail_valid  = 1'b0;
   logic fail_data   = 1'b0;
   logic fail_devopt = 1'b0;
   logic fail_raster = 1'b0;
   logic any_failed;

   logic                   addr_cycle;
   logic                   data_cycle;
   logic [7:0]             sel_q;
   logic [7:0]             opt_q;
   zxuno_pkg::raster_cfg_t cfg_q;
   int                     char_idx_q;
   logic                   exp_valid;
   logic [7:0]             exp_data;
   logic                   exp_valid_q;
   logic [7:0]             exp_data_q;

   assign any_failed = fail_reset | fail_valid | fail_data | fail_devopt | fail_raster;
   assign addr_cycle = bus.iorq && (bus.addr == zxuno_pkg::ZXUNO_ADDR_PORT);
   assign data_cycle = bus.iorq && (bus.addr == zxuno_pkg::ZXUNO_DATA_PORT);

   // Character idx of the string counted from the left and zero past the end
   function automatic logic [7:0] id_char(input int idx);
      logic [63:0] shifted;
      shifted = CORE_ID_TEXT << (8 * idx);
      if (idx >= NUM_CHARS) begin
         return 8'h00;
      end
      return shifted[63:56];
   endfunction

   // ----------------------------------------
   // Expected response of this bus cycle
   // ----------------------------------------
   always_comb begin
      exp_valid = 1'b0;
      exp_data  = 8'hFF;
      if (addr_cycle && bus.rd) begin
         exp_valid = 1'b1;
         exp_data  = sel_q;
      end else if (data_cycle && bus.rd) begin
         exp_valid = 1'b1;
         case (sel_q)
            zxuno_pkg::REG_COREID:     exp_data = id_char(char_idx_q);
            zxuno_pkg::REG_DEVOPTIONS: exp_data = opt_q;
            zxuno_pkg::REG_RASTERLINE: exp_data = cfg_q.raster_line[7:0];
            zxuno_pkg::REG_RASTERCTRL: exp_data = {5'b00000, cfg_q.rasterint_enable,
                                                   cfg_q.vretraceint_disable,
                                                   cfg_q.raster_line[8]};
            default: begin
               exp_valid = 1'b0;
               exp_data  = 8'hFF;
            end
         endcase
      end
   end

   // Register model updated at the edge that ends each access
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sel_q       <= '0;
         opt_q       <= '0;
         cfg_q       <= '0;
         char_idx_q  <= 0;
         exp_valid_q <= 1'b0;
         exp_data_q  <= 8'hFF;
      end else begin
         exp_valid_q <= exp_valid;
         exp_data_q  <= exp_data;
         if (addr_cycle && bus.wr) begin
            sel_q      <= bus.wdata;
            char_idx_q <= 0;
         end else if (data_cycle && bus.rd && (sel_q == zxuno_pkg::REG_COREID)
                      && (char_idx_q < NUM_CHARS)) begin
            char_idx_q <= char_idx_q + 1;
         end
         if (data_cycle && bus.wr) begin
            case (sel_q)
               zxuno_pkg::REG_DEVOPTIONS: opt_q <= bus.wdata;
               zxuno_pkg::REG_RASTERLINE: cfg_q.raster_line[7:0] <= bus.wdata;
               zxuno_pkg::REG_RASTERCTRL: begin
                  cfg_q.rasterint_enable    <= bus.wdata[2];
                  cfg_q.vretraceint_disable <= bus.wdata[1];
                  cfg_q.raster_line[8]      <= bus.wdata[0];
               end
               default: begin
               end
            endcase
         end
      end
   end

   // ----------------------------------------
   // Checks
   // ----------------------------------------
   a_reset_values: assert property (@(posedge clk)
      $rose(arst_n) |-> !rdata_valid && (devopt == '0) && (raster_cfg == '0))
      else begin
         $error("** Error at %0t: outputs not at reset values", $time);
         fail_reset = 1'b1;
      end

   a_read_valid: assert property (@(posedge clk) disable iff (!arst_n)
      rdata_valid == exp_valid_q)
      else begin
         $error("** Error at %0t: rdata_valid %b, expected %b", $time, rdata_valid,
                exp_valid_q);
         fail_valid = 1'b1;
      end

   a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
      rdata == exp_data_q)
      else begin
         $error("** Error at %0t: rdata %h, expected %h", $time, rdata, exp_data_q);
         fail_data = 1'b1;
      end

   // Options byte maps MSB first onto the flags
   a_devopt: assert property (@(posedge clk) disable iff (!arst_n)
      devopt == zxuno_pkg::devopt_flags_t'(opt_q))
      else begin
         $error("** Error at %0t: devopt %h, expected %h", $time, devopt, opt_q);
         fail_devopt = 1'b1;
      end

   a_raster_cfg: assert property (@(posedge clk) disable iff (!arst_n)
      raster_cfg == cfg_q)
      else begin
         $error("** Error at %0t: raster_cfg %h, expected %h", $time, raster_cfg, cfg_q);
         fail_raster = 1'b1;
      end

endmodule

bind zxuno_regs_top zxuno_regs_assertions #(
   .CORE_ID_TEXT (CORE_ID_TEXT)
) i_checks (
   .clk         (clk),
   .arst_n      (arst_n),
   .bus         (bus),
   .rdata       (rdata),
   .rdata_valid (rdata_valid),
   .devopt      (devopt),
   .raster_cfg  (raster_cfg)
);
